/* game_cfg.svh */
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

////////////////////
// grid geometry
////////////////////

// tiles per side, grid is square
`define GRID_DIM 3

////////////////////
// game rules
////////////////////

// first level, also the score after a restart
`define FIRST_LEVEL 5
// finishing this level wins the game
`define LAST_LEVEL 9
// lives given at the start of every game
`define START_LIVES 3

////////////////////
// display
////////////////////

// refresh counter width, msb picks the digit
// kept short for simulation, around 18 on a board
`define REFRESH_BITS 4

`endif

/* game_pkg.sv */
package game_pkg;

    ////////////////////
    // game flow
    ////////////////////

    // generate lasts one cycle while the layout is loaded
    typedef enum logic [2:0] {
        game_generate = 3'd0,
        game_visible  = 3'd1,
        game_hidden   = 3'd2,
        game_won      = 3'd3,
        game_lost     = 3'd4
    } game_state_t;

    ////////////////////
    // grid values
    ////////////////////

    // tile value, 0 is an empty tile
    // same width carries target, level, lives, score
    typedef logic [3:0] tile_num_t;

    // row or column index into the grid
    typedef logic [1:0] coord_t;

endpackage

/* seg_pkg.sv */
package seg_pkg;

    ////////////////////
    // segment side
    ////////////////////

    // active low cathodes, bit 6 is g, bit 0 is a
    typedef logic [6:0] seg_pattern_t;

    // every segment dark
    localparam seg_pattern_t seg_blank = 7'h7f;

    ////////////////////
    // digit side
    ////////////////////

    // active low anode enables, bit 0 is the rightmost digit
    typedef logic [3:0] digit_en_t;

    // all digits off
    localparam digit_en_t an_off   = 4'b1111;
    // rightmost digit carries lives
    localparam digit_en_t an_lives = 4'b1110;
    // next digit to the left carries score
    localparam digit_en_t an_score = 4'b1101;

endpackage

/* input_stage.sv */
`timescale 1ns/1ps

`include "game_cfg.svh"

module input_stage import game_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   left,
    input  logic   right,
    input  logic   up,
    input  logic   down,
    input  logic   sel,
    output logic   pick,
    output coord_t cursor_row,
    output coord_t cursor_col
);

    // highest legal row or column
    localparam coord_t max_coord = coord_t'(`GRID_DIM - 1);

    // button order in the vectors below: left, right, up, down, sel
    logic [4:0] btn_q;
    logic [4:0] btn_prev;
    logic [4:0] btn_rise;

    ////////////////////
    // sampling
    ////////////////////

    // one sample stage, then a copy for the edge compare
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_q    <= '0;
            btn_prev <= '0;
        end else begin
            btn_q    <= {left, right, up, down, sel};
            btn_prev <= btn_q;
        end
    end

    // high now, low on the sample before
    assign btn_rise = btn_q & ~btn_prev;

    ////////////////////
    // cursor and pick
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cursor_row <= '0;
            cursor_col <= '0;
            pick       <= 1'b0;
        end else begin
            // single cycle strobe per press
            pick <= btn_rise[0];
            // left and right move the column, clamped at both edges
            if (btn_rise[4] && cursor_col != '0)
                cursor_col <= cursor_col - 1'b1;
            else if (btn_rise[3] && cursor_col != max_coord)
                cursor_col <= cursor_col + 1'b1;
            // up is toward row 0
            if (btn_rise[2] && cursor_row != '0)
                cursor_row <= cursor_row - 1'b1;
            else if (btn_rise[1] && cursor_row != max_coord)
                cursor_row <= cursor_row + 1'b1;
        end
    end

endmodule

/* game_fsm.sv */
`timescale 1ns/1ps

`include "game_cfg.svh"

module game_fsm import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pick,
    input  coord_t      cursor_row,
    input  coord_t      cursor_col,
    output tile_num_t   lives,
    output tile_num_t   score,
    output game_state_t game_state,
    output tile_num_t   cell_num,
    output logic        cell_full
);

    // whole grid as one word, tile 0 (top left) in the low nibble
    typedef tile_num_t [`GRID_DIM*`GRID_DIM-1:0] grid_t;

    grid_t       grid;
    grid_t       grid_next;
    tile_num_t   target;
    tile_num_t   target_next;
    tile_num_t   level;
    tile_num_t   level_next;
    tile_num_t   lives_next;
    tile_num_t   score_next;
    game_state_t state_next;
    logic [3:0]  cell_idx;
    tile_num_t   cur_tile;

    ////////////////////
    // fixed layouts
    ////////////////////

    // hex digits read from tile 8 down to tile 0
    function automatic grid_t layout(input tile_num_t lvl);
        grid_t g;
        case (lvl)
            4'd5:    g = 36'h004032105;
            4'd6:    g = 36'h354010206;
            4'd7:    g = 36'h514360207;
            4'd8:    g = 36'h263581047;
            4'd9:    g = 36'h357829164;
            default: g = '0;
        endcase
        return g;
    endfunction

    ////////////////////
    // cursor lookup
    ////////////////////

    // row major index of the tile under the cursor
    assign cell_idx = 4'(cursor_row) * 4'(`GRID_DIM) + 4'(cursor_col);
    assign cur_tile = grid[cell_idx];

    assign cell_full = (cur_tile != '0);
    // numbers only readable before the first pick
    assign cell_num  = (game_state == game_visible) ? cur_tile : '0;

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        grid_next   = grid;
        target_next = target;
        level_next  = level;
        lives_next  = lives;
        score_next  = score;
        state_next  = game_state;

        case (game_state)
            game_generate: begin
                grid_next  = layout(level);
                state_next = game_visible;
            end
            game_visible, game_hidden: begin
                if (pick && cur_tile != '0) begin
                    if (cur_tile == target) begin
                        grid_next[cell_idx] = '0;
                        target_next = target + 1'b1;
                        // any correct pick hides the numbers
                        state_next = game_hidden;
                        if (target == level) begin
                            // level finished
                            if (level == tile_num_t'(`LAST_LEVEL)) begin
                                state_next = game_won;
                            end else begin
                                level_next  = level + 1'b1;
                                target_next = 4'd1;
                                state_next  = game_generate;
                                if (score < level_next)
                                    score_next = level_next;
                            end
                        end
                    end else begin
                        // occupied but out of order
                        lives_next = lives - 1'b1;
                        if (lives_next == '0)
                            state_next = game_lost;
                    end
                end
                // empty tile picks fall through untouched
            end
            game_won, game_lost: begin
                // fresh game, layout reloads in generate
                if (pick) begin
                    score_next  = tile_num_t'(`FIRST_LEVEL);
                    lives_next  = tile_num_t'(`START_LIVES);
                    level_next  = tile_num_t'(`FIRST_LEVEL);
                    target_next = 4'd1;
                    state_next  = game_generate;
                end
            end
            default: begin
                state_next = game_generate;
            end
        endcase
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grid       <= '0;
            target     <= 4'd1;
            level      <= tile_num_t'(`FIRST_LEVEL);
            lives      <= tile_num_t'(`START_LIVES);
            score      <= tile_num_t'(`FIRST_LEVEL);
            game_state <= game_generate;
        end else begin
            grid       <= grid_next;
            target     <= target_next;
            level      <= level_next;
            lives      <= lives_next;
            score      <= score_next;
            game_state <= state_next;
        end
    end

endmodule

/* status_display.sv */
`timescale 1ns/1ps

`include "game_cfg.svh"

module status_display import game_pkg::*; import seg_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  tile_num_t    lives,
    input  tile_num_t    score,
    output seg_pattern_t cathode,
    output digit_en_t    anode
);

    logic [`REFRESH_BITS-1:0] refresh_cnt;
    logic                     show_score;
    seg_pattern_t             lives_seg;
    seg_pattern_t             score_seg;

    ////////////////////
    // digit decoder
    ////////////////////

    // decimal digit to active low g..a, anything above 9 is dark
    function automatic seg_pattern_t dec_digit(input tile_num_t d);
        seg_pattern_t s;
        case (d)
            4'd0:    s = 7'h40;
            4'd1:    s = 7'h79;
            4'd2:    s = 7'h24;
            4'd3:    s = 7'h30;
            4'd4:    s = 7'h19;
            4'd5:    s = 7'h12;
            4'd6:    s = 7'h02;
            4'd7:    s = 7'h78;
            4'd8:    s = 7'h00;
            4'd9:    s = 7'h10;
            default: s = seg_blank;
        endcase
        return s;
    endfunction

    assign lives_seg = dec_digit(lives);
    assign score_seg = dec_digit(score);

    ////////////////////
    // multiplexing
    ////////////////////

    // msb of the free running counter alternates the two digits
    assign show_score = refresh_cnt[`REFRESH_BITS-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refresh_cnt <= '0;
            // dark until the first refresh
            anode       <= an_off;
            cathode     <= seg_blank;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
            anode       <= show_score ? an_score : an_lives;
            cathode     <= show_score ? score_seg : lives_seg;
        end
    end

endmodule

/* memory_game_top.sv */
`timescale 1ns/1ps

module memory_game_top import game_pkg::*; import seg_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         left,
    input  logic         right,
    input  logic         up,
    input  logic         down,
    input  logic         sel,
    output seg_pattern_t cathode,
    output digit_en_t    anode,
    output coord_t       cursor_row,
    output coord_t       cursor_col,
    output tile_num_t    cell_num,
    output logic         cell_full,
    output game_state_t  game_state
);

    // select strobe into the game
    logic      pick;
    // game counters out to the display
    tile_num_t lives;
    tile_num_t score;

    ////////////////////
    // stage 1, buttons
    ////////////////////

    input_stage u_input_stage (
        .clk        (clk),
        .rst        (rst),
        .left       (left),
        .right      (right),
        .up         (up),
        .down       (down),
        .sel        (sel),
        .pick       (pick),
        .cursor_row (cursor_row),
        .cursor_col (cursor_col)
    );

    ////////////////////
    // stage 2, rules
    ////////////////////

    game_fsm u_game_fsm (
        .clk        (clk),
        .rst        (rst),
        .pick       (pick),
        .cursor_row (cursor_row),
        .cursor_col (cursor_col),
        .lives      (lives),
        .score      (score),
        .game_state (game_state),
        .cell_num   (cell_num),
        .cell_full  (cell_full)
    );

    ////////////////////
    // stage 3, display
    ////////////////////

    status_display u_status_display (
        .clk     (clk),
        .rst     (rst),
        .lives   (lives),
        .score   (score),
        .cathode (cathode),
        .anode   (anode)
    );

endmodule

/* tb_memory_game.sv */
`timescale 1ns/1ps

`include "game_cfg.svh"

module tb_memory_game import game_pkg::*, seg_pkg::*; ();

    localparam int clk_period     = 100;
    // bit positions in btns, same order as the button ports
    localparam int btn_left       = 4;
    localparam int btn_right      = 3;
    localparam int btn_up         = 2;
    localparam int btn_down       = 1;
    localparam int btn_sel        = 0;
    // run length budget for the watchdog
    localparam int max_presses    = 300;
    localparam int press_cycles   = 10;
    localparam int display_reads  = 20;
    localparam int display_cycles = 4 << `REFRESH_BITS;
    localparam int limit_cycles   = 20 + max_presses * press_cycles
                                    + display_reads * display_cycles;

    logic         clk;
    logic         rst;
    logic [4:0]   btns;
    seg_pattern_t cathode;
    digit_en_t    anode;
    coord_t       cursor_row;
    coord_t       cursor_col;
    tile_num_t    cell_num;
    logic         cell_full;
    game_state_t  game_state;

    // reference model state
    logic [3:0]   m_grid [0:8];
    logic [3:0]   m_target;
    logic [3:0]   m_level;
    logic [3:0]   m_lives;
    logic [3:0]   m_score;
    game_state_t  m_state;
    int           m_row;
    int           m_col;
    // model valid, only toggled right after a rising edge
    logic         chk_on;
    int           seed;

    memory_game_top DUT (
        .clk        (clk),
        .rst        (rst),
        .left       (btns[btn_left]),
        .right      (btns[btn_right]),
        .up         (btns[btn_up]),
        .down       (btns[btn_down]),
        .sel        (btns[btn_sel]),
        .cathode    (cathode),
        .anode      (anode),
        .cursor_row (cursor_row),
        .cursor_col (cursor_col),
        .cell_num   (cell_num),
        .cell_full  (cell_full),
        .game_state (game_state)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////
    // reference model
    ////////////////////

    // level layouts, row major, 0 is empty
    function automatic logic [3:0] layout_tile(input logic [3:0] lvl, input int idx);
        logic [3:0] t [0:8];
        case (lvl)
            4'd5:    t = '{5, 0, 1, 2, 3, 0, 4, 0, 0};
            4'd6:    t = '{6, 0, 2, 0, 1, 0, 4, 5, 3};
            4'd7:    t = '{7, 0, 2, 0, 6, 3, 4, 1, 5};
            4'd8:    t = '{7, 4, 0, 1, 8, 5, 3, 6, 2};
            4'd9:    t = '{4, 6, 1, 9, 2, 8, 7, 5, 3};
            default: t = '{default: 4'd0};
        endcase
        return t[idx];
    endfunction

    function automatic void load_layout();
        for (int i = 0; i < 9; i++)
            m_grid[i] = layout_tile(m_level, i);
    endfunction

    // one select press on tile idx, generate already passed
    function automatic void apply_pick(input int idx);
        if (m_state == game_won || m_state == game_lost) begin
            m_lives  = `START_LIVES;
            m_score  = `FIRST_LEVEL;
            m_level  = `FIRST_LEVEL;
            m_target = 4'd1;
            load_layout();
            m_state  = game_visible;
        end else if (m_grid[idx] == m_target) begin
            m_grid[idx] = 4'd0;
            m_state     = game_hidden;
            if (m_target == m_level && m_level == `LAST_LEVEL) begin
                m_state = game_won;
            end else if (m_target == m_level) begin
                // next level, fresh layout shown again
                m_level  = m_level + 4'd1;
                if (m_score < m_level)
                    m_score = m_level;
                m_target = 4'd1;
                load_layout();
                m_state  = game_visible;
            end else begin
                m_target = m_target + 4'd1;
            end
        end else if (m_grid[idx] != 4'd0) begin
            m_lives = m_lives - 4'd1;
            if (m_lives == 4'd0)
                m_state = game_lost;
        end
    endfunction

    function automatic int find_tile(input int n);
        int idx;
        idx = -1;
        for (int i = 0; i < 9; i++)
            if (m_grid[i] == n)
                idx = i;
        return idx;
    endfunction

    // active low g..a back to a decimal digit, 15 if no digit matches
    function automatic int seg_digit(input logic [6:0] cath);
        logic [6:0] on;
        on = ~cath;
        case (on)
            7'h3f:   return 0;
            7'h06:   return 1;
            7'h5b:   return 2;
            7'h4f:   return 3;
            7'h66:   return 4;
            7'h6d:   return 5;
            7'h7d:   return 6;
            7'h07:   return 7;
            7'h7f:   return 8;
            7'h6f:   return 9;
            default: return 15;
        endcase
    endfunction

    ////////////////////
    // checking
    ////////////////////

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // outputs settle after the rising edge, sampled on the falling one
    always @(negedge clk) begin : compare_outputs
        int idx;
        if (chk_on) begin
            idx = m_row * `GRID_DIM + m_col;
            check_val("cursor_row", cursor_row, m_row);
            check_val("cursor_col", cursor_col, m_col);
            check_val("game_state", game_state, m_state);
            check_val("cell_full", cell_full, m_grid[idx] != 4'd0);
            check_val("cell_num", cell_num, (m_state == game_visible) ? m_grid[idx] : 4'd0);
        end
    end

    initial begin
        #(limit_cycles * clk_period);
        $display("watchdog expired, the run did not finish in time");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    ////////////////////
    // stimulus
    ////////////////////

    // hold 3 cycles, release 3 cycles, then the model catches up
    task automatic press_button(input int b);
        @(posedge clk);
        chk_on = 1'b0;
        @(negedge clk);
        btns[b] = 1'b1;
        repeat (3) @(negedge clk);
        btns[b] = 1'b0;
        repeat (3) @(negedge clk);
        @(posedge clk);
        case (b)
            btn_left:  if (m_col > 0) m_col--;
            btn_right: if (m_col < `GRID_DIM - 1) m_col++;
            btn_up:    if (m_row > 0) m_row--;
            btn_down:  if (m_row < `GRID_DIM - 1) m_row++;
            default:   apply_pick(m_row * `GRID_DIM + m_col);
        endcase
        chk_on = 1'b1;
        @(negedge clk);
    endtask

    task automatic move_to(input int row, input int col);
        while (m_row > row) press_button(btn_up);
        while (m_row < row) press_button(btn_down);
        while (m_col > col) press_button(btn_left);
        while (m_col < col) press_button(btn_right);
    endtask

    task automatic pick_at(input int idx);
        move_to(idx / `GRID_DIM, idx % `GRID_DIM);
        press_button(btn_sel);
    endtask

    // every tile gets compared once on the way
    task automatic walk_grid();
        for (int r = 0; r < `GRID_DIM; r++)
            for (int c = 0; c < `GRID_DIM; c++)
                move_to(r, c);
    endtask

    // any occupied tile that is not the next number
    task automatic wrong_pick();
        int cand [$];
        int idx;
        for (int i = 0; i < 9; i++)
            if (m_grid[i] != 4'd0 && m_grid[i] != m_target)
                cand.push_back(i);
        idx = cand[$unsigned($random(seed)) % cand.size()];
        pick_at(idx);
    endtask

    // lives on the rightmost digit, score on the next one
    task automatic read_display(input int exp_lives, input int exp_score);
        int waited;
        waited = 0;
        while (anode != 4'b1110 && waited < display_cycles) begin
            @(negedge clk);
            waited++;
        end
        check_val("anode", anode, 4'b1110);
        check_val("lives digit", seg_digit(cathode), exp_lives);
        waited = 0;
        while (anode != 4'b1101 && waited < display_cycles) begin
            @(negedge clk);
            waited++;
        end
        check_val("anode", anode, 4'b1101);
        check_val("score digit", seg_digit(cathode), exp_score);
    endtask

    initial begin
        seed     = 67;
        btns     = '0;
        rst      = 1'b1;
        chk_on   = 1'b0;
        m_row    = 0;
        m_col    = 0;
        m_level  = `FIRST_LEVEL;
        m_score  = `FIRST_LEVEL;
        m_lives  = `START_LIVES;
        m_target = 4'd1;
        m_state  = game_visible;
        load_layout();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        @(posedge clk);
        chk_on = 1'b1;
        @(negedge clk);

        // reset layout, edges at both corners
        check_val("cell_num", cell_num, 4'd5);
        press_button(btn_up);
        press_button(btn_left);
        walk_grid();
        press_button(btn_down);
        press_button(btn_right);
        read_display(3, 5);

        // first pick hides, empty tile does nothing
        pick_at(find_tile(1));
        check_val("game_state", game_state, game_hidden);
        move_to(1, 0);
        pick_at(1);
        read_display(3, 5);

        // three wrong picks, then restart from lost
        wrong_pick();
        read_display(2, 5);
        wrong_pick();
        read_display(1, 5);
        wrong_pick();
        check_val("game_state", game_state, game_lost);
        read_display(0, 5);
        press_button(btn_sel);
        read_display(3, 5);
        walk_grid();

        // whole game, score follows the level
        for (int lvl = `FIRST_LEVEL; lvl <= `LAST_LEVEL; lvl++) begin
            for (int n = 1; n <= lvl; n++)
                pick_at(find_tile(n));
            read_display(3, (lvl < `LAST_LEVEL) ? lvl + 1 : `LAST_LEVEL);
        end
        check_val("game_state", game_state, game_won);
        press_button(btn_sel);
        check_val("game_state", game_state, game_visible);
        read_display(3, 5);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
game_pkg.sv
seg_pkg.sv
input_stage.sv
game_fsm.sv
status_display.sv
memory_game_top.sv
tb_memory_game.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the memory game testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_memory_game

# keep the output even when the run stops on an error
out=$(./obj_dir/Vtb_memory_game 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
